// File: project.f
+incdir+include
design/osc_pkg.sv
design/phase_if.sv
design/phase_accumulator.sv
design/offset_registers.sv
design/sine_quarter_rom.sv
design/wave_shaper.sv
design/osc_voice_top.sv
tests/osc_tb.sv

// File: tests/osc_tb.sv
`include "osc_macros.svh"

module osc_tb;

    localparam int PERIOD = 20;
    // reset and sweep, register bus, directed slots, then the random stream
    localparam int RUN_CYCLES = 10 + 40 + 40 + (16 + 5 + 48) * 4 + 300 * 8;

    logic                        read = 1'b0;
    logic                        reset_data_N;
    logic                        slot_valid;
    logic                        slot_ready;
    logic [`VOICE_W-1:0]         slot_voice;
    logic [`OSC_W-1:0]           slot_osc;
    logic [`ACC_W-1:0]           pitch_inc;
    logic signed [`PHASE_W-1:0]  modulation;
    logic                        accum_zero;
    logic                        sample_valid;
    logic                        sample_ready;
    logic [`VOICE_W-1:0]         sample_voice;
    logic [`OSC_W-1:0]           sample_osc;
    logic signed [`SAMPLE_W-1:0] sample_value;
    logic                        reg_write;
    logic                        reg_read;
    logic [`REG_ADDR_W-1:0]      reg_addr;
    logic [`REG_DATA_W-1:0]      reg_wdata;
    logic [`REG_DATA_W-1:0]      reg_rdata;

    // reference model state
    logic [`ACC_W-1:0]           acc_model [0:`VOICES*`OSCS-1];
    logic signed [`OFFSET_W-1:0] off_model [0:`OSCS-1];
    logic [`SLOT_W-1:0]          exp_tag [$];
    int                          exp_val [$];
    logic [31:0]                 rnd_state;
    logic [31:0]                 rdy_state;
    logic                        random_ready;
    int                          errors;
    int                          errors_mark;
    time                         accept_time;

    osc_voice_top uut (.*);

    always #(PERIOD / 2) read = ~read;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    // quarter table rule with mirroring and sign per quadrant
    function automatic int ref_sample(input int phase, input int mod, input int off);
        int  addr;
        int  quad;
        int  idx;
        real ang;
        int  mag;
        addr = (phase + mod + off * 8) & 2047;
        quad = addr >> 9;
        idx  = (quad % 2 == 1) ? `QUARTER_LEN - (addr & 511) : (addr & 511);
        ang  = 2.0 * 3.14159265358979323846 * idx / (4.0 * `QUARTER_LEN);
        mag  = $rtoi(real'(`SINE_AMP) * $sin(ang) + 0.5);
        return (quad >= 2) ? -mag : mag;
    endfunction

    function automatic int offset_index(input int addr);
        for (int o = 0; o < `OSCS; o++) begin
            if (addr == `OFFSET_BASE + `OFFSET_STRIDE * o) begin
                return o;
            end
        end
        return -1;
    endfunction

    task automatic compare(input string name, input int got, input int expected);
        if (got !== expected) begin
            errors++;
            $display("error t=%0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic test_done(input string name);
        $display("%-20s finished with %0d errors", name, errors - errors_mark);
        errors_mark = errors;
    endtask

    task automatic write_reg(input int addr, input logic [7:0] data);
        @(negedge read);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge read);
        reg_write = 1'b0;
        if (offset_index(addr) >= 0) begin
            off_model[offset_index(addr)] = data;
        end
    endtask

    task automatic read_reg(input int addr);
        int expected;
        expected = (offset_index(addr) >= 0) ? $unsigned(off_model[offset_index(addr)]) : 0;
        @(negedge read);
        reg_read = 1'b1;
        reg_addr = addr;
        @(negedge read);
        reg_read = 1'b0;
        compare("reg_rdata", reg_rdata, expected);
    endtask

    task automatic idle_cycles(input int n);
        @(negedge read);
        slot_valid = 1'b0;
        repeat (n - 1) @(negedge read);
    endtask

    // holds the slot until slot_ready is seen at a rising edge
    task automatic send_slot(input logic [2:0] voice, input logic [1:0] osc,
                             input logic [23:0] inc, input logic [10:0] mod,
                             input logic zero);
        int waited;
        @(negedge read);
        slot_valid = 1'b1;
        slot_voice = voice;
        slot_osc   = osc;
        pitch_inc  = inc;
        modulation = mod;
        accum_zero = zero;
        waited     = 0;
        do begin
            @(posedge read);
            waited++;
        end while (!slot_ready && waited < 200);
        accept_time = $time;
        if (!slot_ready) begin
            errors++;
            $display("slot for voice %0d osc %0d was never accepted", voice, osc);
        end
    endtask

    task automatic wait_drain();
        int waited;
        idle_cycles(1);
        waited = 0;
        while ((exp_tag.size() != 0 || sample_valid) && waited < 500) begin
            @(negedge read);
            waited++;
        end
        if (exp_tag.size() != 0) begin
            errors++;
            $display("%0d expected samples never came out", exp_tag.size());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // model and compare
    ////////////////////////////////////////////////////////////

    always @(posedge read) begin : model_update
        logic [`SLOT_W-1:0] slot;
        logic [`ACC_W-1:0]  acc_next;
        if (reset_data_N && slot_valid && slot_ready) begin
            slot           = {slot_voice, slot_osc};
            acc_next       = (accum_zero ? '0 : acc_model[slot]) + pitch_inc;
            acc_model[slot] = acc_next;
            exp_tag.push_back(slot);
            exp_val.push_back(ref_sample(acc_next[`ACC_W-1 -: `PHASE_W], modulation,
                                         off_model[slot_osc]));
        end
    end

    always @(posedge read) begin
        if (reset_data_N && sample_valid && sample_ready) begin
            if (exp_tag.size() == 0) begin
                errors++;
                $display("sample came out at t=%0t with no slot accepted for it", $time);
            end else begin
                compare("sample_voice", sample_voice, exp_tag[0][`SLOT_W-1:`OSC_W]);
                compare("sample_osc", sample_osc, exp_tag[0][`OSC_W-1:0]);
                compare("sample_value", sample_value, exp_val[0]);
                void'(exp_tag.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    // sample_ready is random only during the stream test
    always @(negedge read) begin
        rdy_state    = xorshift(rdy_state);
        sample_ready = random_ready ? rdy_state[7] : 1'b1;
    end

    initial begin
        #((RUN_CYCLES + 200) * PERIOD);
        $display("timeout after %0d cycles, the tests did not finish", RUN_CYCLES + 200);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] q;
        int          waited;
        reset_data_N = 1'b0;
        slot_valid   = 1'b0;
        slot_voice   = '0;
        slot_osc     = '0;
        pitch_inc    = '0;
        modulation   = '0;
        accum_zero   = 1'b0;
        sample_ready = 1'b1;
        reg_write    = 1'b0;
        reg_read     = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        random_ready = 1'b0;
        errors       = 0;
        errors_mark  = 0;
        rnd_state    = 32'd35638;
        rdy_state    = xorshift(32'd35638 ^ 32'h9e3779b9);
        for (int i = 0; i < `VOICES * `OSCS; i++) acc_model[i] = '0;
        for (int o = 0; o < `OSCS; o++) off_model[o] = '0;
        repeat (10) @(negedge read);
        reset_data_N = 1'b1;
        waited = 0;
        while (!slot_ready && waited < 100) begin
            @(negedge read);
            waited++;
        end
        if (!slot_ready) begin
            errors++;
            $display("slot_ready stayed low after the reset sweep");
        end

        for (int o = 0; o < `OSCS; o++) read_reg(`OFFSET_BASE + `OFFSET_STRIDE * o);
        write_reg(6, 8'h12);
        write_reg(22, 8'hf3);
        write_reg(38, 8'h7f);
        write_reg(54, 8'h80);
        write_reg(7, 8'h55);
        write_reg(100, 8'haa);
        for (int o = 0; o < `OSCS; o++) read_reg(`OFFSET_BASE + `OFFSET_STRIDE * o);
        read_reg(7);
        read_reg(100);
        test_done("register bus");

        for (int i = 0; i < 16; i++) send_slot(3'd2, 2'd1, 24'h0c49ba, '0, 1'b0);
        wait_drain();
        test_done("single slot ramp");

        send_slot(3'd5, 2'd3, 24'h123456, '0, 1'b0);
        send_slot(3'd2, 2'd1, 24'h050000, '0, 1'b1);
        send_slot(3'd5, 2'd3, 24'h123456, '0, 1'b0);
        send_slot(3'd2, 2'd1, 24'h050000, '0, 1'b0);
        send_slot(3'd2, 2'd1, 24'h050000, '0, 1'b1);
        wait_drain();
        test_done("accumulator zero");

        // offsets change only with the stream idle
        for (int round = 0; round < 2; round++) begin
            for (int o = 0; o < `OSCS; o++) begin
                r = rand32();
                write_reg(`OFFSET_BASE + `OFFSET_STRIDE * o, r[7:0]);
            end
            for (int i = 0; i < 24; i++) begin
                r = rand32();
                q = rand32();
                send_slot(r[4:2], r[1:0], q[23:0], r[31:21], 1'b0);
            end
            wait_drain();
        end
        test_done("offsets and mod");

        random_ready = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r = rand32();
            q = rand32();
            if (r[8]) idle_cycles(1 + r[10:9]);
            send_slot(r[4:2], r[1:0], q[23:0], r[31:21], r[14:12] == 3'd0);
        end
        wait_drain();
        random_ready = 1'b0;
        test_done("back-pressure stream");

        idle_cycles(4);
        send_slot(3'd3, 2'd2, 24'h200000, '0, 1'b0);
        @(negedge read);
        slot_valid = 1'b0;
        waited = 0;
        while (!sample_valid && waited < 20) begin
            @(negedge read);
            waited++;
        end
        compare("latency", int'(($time - accept_time - PERIOD / 2) / PERIOD), 3);
        wait_drain();
        test_done("latency");

        $display("all tests finished with %0d errors in total", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: design/osc_voice_top.sv
`include "osc_macros.svh"

module osc_voice_top (
    input  logic                        read,
    input  logic                        reset_data_N,
    input  logic                        slot_valid,
    output logic                        slot_ready,
    input  logic [`VOICE_W-1:0]         slot_voice,
    input  logic [`OSC_W-1:0]           slot_osc,
    input  logic [`ACC_W-1:0]           pitch_inc,
    input  logic signed [`PHASE_W-1:0]  modulation,
    input  logic                        accum_zero,
    output logic                        sample_valid,
    input  logic                        sample_ready,
    output logic [`VOICE_W-1:0]         sample_voice,
    output logic [`OSC_W-1:0]           sample_osc,
    output logic signed [`SAMPLE_W-1:0] sample_value,
    input  logic                        reg_write,
    input  logic                        reg_read,
    input  logic [`REG_ADDR_W-1:0]      reg_addr,
    input  logic [`REG_DATA_W-1:0]      reg_wdata,
    output logic [`REG_DATA_W-1:0]      reg_rdata
);

    osc_pkg::slot_tag_u          slot_tag;
    osc_pkg::slot_tag_u          sample_tag;
    logic [`OSC_W-1:0]           lookup_osc;
    logic signed [`OFFSET_W-1:0] lookup_offset;

    phase_if ph ();

    // tag in, tag out
    assign slot_tag.f.voice = slot_voice;
    assign slot_tag.f.osc   = slot_osc;
    assign sample_voice     = sample_tag.f.voice;
    assign sample_osc       = sample_tag.f.osc;

    phase_accumulator u_acc (
        .read         (read),
        .reset_data_N (reset_data_N),
        .in_valid     (slot_valid),
        .in_ready     (slot_ready),
        .in_tag       (slot_tag),
        .in_inc       (pitch_inc),
        .in_mod       (modulation),
        .in_zero      (accum_zero),
        .ph           (ph.source)
    );

    offset_registers u_offs (
        .read          (read),
        .reset_data_N  (reset_data_N),
        .reg_write     (reg_write),
        .reg_read      (reg_read),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .lookup_osc    (lookup_osc),
        .lookup_offset (lookup_offset)
    );

    wave_shaper u_shaper (
        .read          (read),
        .reset_data_N  (reset_data_N),
        .ph            (ph.sink),
        .lookup_osc    (lookup_osc),
        .lookup_offset (lookup_offset),
        .out_valid     (sample_valid),
        .out_ready     (sample_ready),
        .out_tag       (sample_tag),
        .out_value     (sample_value)
    );

endmodule

// File: design/wave_shaper.sv
`include "osc_macros.svh"

module wave_shaper (
    input  logic                        read,
    input  logic                        reset_data_N,
    phase_if.sink                       ph,
    output logic [`OSC_W-1:0]           lookup_osc,
    input  logic signed [`OFFSET_W-1:0] lookup_offset,
    output logic                        out_valid,
    input  logic                        out_ready,
    output osc_pkg::slot_tag_u          out_tag,
    output logic signed [`SAMPLE_W-1:0] out_value
);

    logic [`PHASE_W-1:0]         addr;
    logic [1:0]                  quadrant;
    logic [`PHASE_W-3:0]         position;
    logic [`PHASE_W-2:0]         index_d;

    logic                        s1_valid;
    logic                        s1_neg;
    osc_pkg::slot_tag_u          s1_tag;
    logic [`PHASE_W-2:0]         s1_index;

    logic                        s2_valid;
    logic                        s2_neg;
    osc_pkg::slot_tag_u          s2_tag;
    logic [`SAMPLE_W-2:0]        rom_word;
    logic signed [`SAMPLE_W-1:0] magnitude;

    logic                        out_adv;
    logic                        s2_adv;
    logic                        s1_adv;

    // a stage loads when empty or when its consumer moves
    assign out_adv  = !out_valid || out_ready;
    assign s2_adv   = !s2_valid || out_adv;
    assign s1_adv   = !s1_valid || s2_adv;
    assign ph.ready = s1_adv;

    ////////////////////////////////////////////////////////////
    // stage 1: address and quadrant
    ////////////////////////////////////////////////////////////

    assign lookup_osc = ph.tag.f.osc;

    // wraps modulo 2048
    assign addr     = ph.phase + $unsigned(ph.modulation) + {lookup_offset, 3'b000};
    assign quadrant = addr[`PHASE_W-1 -: 2];
    assign position = addr[`PHASE_W-3:0];

    // falling quarters read the table backwards
    assign index_d = quadrant[0] ? (`PHASE_W-1)'(`QUARTER_LEN) - {1'b0, position}
                                 : {1'b0, position};

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            s1_valid <= 1'b0;
        end else if (s1_adv) begin
            s1_valid <= ph.valid;
        end
    end

    always_ff @(posedge read) begin
        if (s1_adv) begin
            s1_neg   <= quadrant[1];
            s1_tag   <= ph.tag;
            s1_index <= index_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2: table word
    ////////////////////////////////////////////////////////////

    sine_quarter_rom u_rom (
        .read  (read),
        .en    (s2_adv),
        .index (s1_index),
        .value (rom_word)
    );

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            s2_valid <= 1'b0;
        end else if (s2_adv) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge read) begin
        if (s2_adv) begin
            s2_neg <= s1_neg;
            s2_tag <= s1_tag;
        end
    end

    ////////////////////////////////////////////////////////////
    // output register, sign applied
    ////////////////////////////////////////////////////////////

    assign magnitude = {1'b0, rom_word};

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            out_valid <= 1'b0;
        end else if (out_adv) begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge read) begin
        if (out_adv) begin
            out_tag   <= s2_tag;
            out_value <= s2_neg ? -magnitude : magnitude;
        end
    end

    out_held: assert property (
        @(posedge read) disable iff (!reset_data_N)
        out_valid && !out_ready |=> out_valid
    );

endmodule

// File: design/sine_quarter_rom.sv
`include "osc_macros.svh"

module sine_quarter_rom (
    input  logic                  read,
    input  logic                  en,
    input  logic [`PHASE_W-2:0]   index,
    output logic [`SAMPLE_W-2:0]  value
);

    // entries 0..512 cover a quarter period inclusive
    logic [`SAMPLE_W-2:0] table_mem [0:`QUARTER_LEN];

    ////////////////////////////////////////////////////////////
    // table fill
    ////////////////////////////////////////////////////////////

    initial begin
        real angle;
        real scaled;
        for (int k = 0; k <= `QUARTER_LEN; k++) begin
            // full period is 4 quarters of table steps
            angle  = 2.0 * 3.14159265358979323846 * k / (4.0 * `QUARTER_LEN);
            scaled = `SINE_AMP * $sin(angle);
            table_mem[k] = (`SAMPLE_W-1)'($rtoi(scaled + 0.5));
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // holds the word while the next stage is stalled
    always_ff @(posedge read) begin
        if (en) begin
            value <= table_mem[index];
        end
    end

endmodule

// File: design/offset_registers.sv
`include "osc_macros.svh"

module offset_registers (
    input  logic                        read,
    input  logic                        reset_data_N,
    input  logic                        reg_write,
    input  logic                        reg_read,
    input  logic [`REG_ADDR_W-1:0]      reg_addr,
    input  logic [`REG_DATA_W-1:0]      reg_wdata,
    output logic [`REG_DATA_W-1:0]      reg_rdata,
    input  logic [`OSC_W-1:0]           lookup_osc,
    output logic signed [`OFFSET_W-1:0] lookup_offset
);

    logic signed [`OFFSET_W-1:0] offs [0:`OSCS-1];
    logic [`OSCS-1:0]            hit;
    logic [`REG_DATA_W-1:0]      rd_mux;

    // one address per oscillator, base plus stride
    always_comb begin
        for (int o = 0; o < `OSCS; o++) begin
            hit[o] = (reg_addr == `REG_ADDR_W'(`OFFSET_BASE + `OFFSET_STRIDE * o));
        end
    end

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            for (int o = 0; o < `OSCS; o++) begin
                offs[o] <= '0;
            end
        end else if (reg_write) begin
            for (int o = 0; o < `OSCS; o++) begin
                if (hit[o]) begin
                    offs[o] <= reg_wdata;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // unmatched address gives zero
    always_comb begin
        rd_mux = '0;
        for (int o = 0; o < `OSCS; o++) begin
            if (hit[o]) begin
                rd_mux = offs[o];
            end
        end
    end

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            reg_rdata <= '0;
        end else if (reg_read) begin
            reg_rdata <= rd_mux;
        end
    end

    // wave shaper lookup
    assign lookup_offset = offs[lookup_osc];

    bus_no_overlap: assert property (
        @(posedge read) disable iff (!reset_data_N)
        !(reg_write && reg_read)
    );

endmodule

// File: design/phase_accumulator.sv
`include "osc_macros.svh"

module phase_accumulator (
    input  logic                       read,
    input  logic                       reset_data_N,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  osc_pkg::slot_tag_u         in_tag,
    input  logic [`ACC_W-1:0]          in_inc,
    input  logic signed [`PHASE_W-1:0] in_mod,
    input  logic                       in_zero,
    phase_if.source                    ph
);

    // one accumulator per slot
    logic [`ACC_W-1:0]  acc_mem [0:`VOICES*`OSCS-1];

    logic               sweep_busy;
    logic [`SLOT_W-1:0] sweep_idx;
    logic               accept;
    logic [`ACC_W-1:0]  acc_old;
    logic [`ACC_W-1:0]  acc_new;

    assign in_ready = !sweep_busy && (!ph.valid || ph.ready);
    assign accept   = in_valid && in_ready;

    assign acc_old = acc_mem[in_tag.flat];
    assign acc_new = (in_zero ? '0 : acc_old) + in_inc;

    ////////////////////////////////////////////////////////////
    // reset sweep
    ////////////////////////////////////////////////////////////

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            sweep_busy <= 1'b1;
            sweep_idx  <= '0;
        end else if (sweep_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == `SLOT_W'(`VOICES*`OSCS-1)) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    // sweep has priority, input is blocked while it runs
    always_ff @(posedge read) begin
        if (sweep_busy) begin
            acc_mem[sweep_idx] <= '0;
        end else if (accept) begin
            acc_mem[in_tag.flat] <= acc_new;
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            ph.valid <= 1'b0;
        end else if (accept) begin
            ph.valid <= 1'b1;
        end else if (ph.ready) begin
            ph.valid <= 1'b0;
        end
    end

    // table phase is the top of the new accumulator value
    always_ff @(posedge read) begin
        if (accept) begin
            ph.tag        <= in_tag;
            ph.phase      <= acc_new[`ACC_W-1 -: `PHASE_W];
            ph.modulation <= in_mod;
        end
    end

    // held phase must not change under a stalled sink
    ph_hold_stable: assert property (
        @(posedge read) disable iff (!reset_data_N)
        ph.valid && !ph.ready |=> ph.valid && $stable(ph.tag) &&
            $stable(ph.phase) && $stable(ph.modulation)
    );

endmodule

// File: design/phase_if.sv
`include "osc_macros.svh"

// tagged phase from accumulator to wave shaper
interface phase_if;

    logic                       valid;
    logic                       ready;
    osc_pkg::slot_tag_u         tag;
    logic [`PHASE_W-1:0]        phase;
    logic signed [`PHASE_W-1:0] modulation;

    modport source (
        output valid,
        output tag,
        output phase,
        output modulation,
        input  ready
    );

    modport sink (
        input  valid,
        input  tag,
        input  phase,
        input  modulation,
        output ready
    );

endinterface

// File: design/osc_pkg.sv
`include "osc_macros.svh"

package osc_pkg;

    ////////////////////////////////////////////////////////////
    // slot tag
    ////////////////////////////////////////////////////////////

    // voice in the high bits, oscillator in the low bits
    typedef struct packed {
        logic [`VOICE_W-1:0] voice;
        logic [`OSC_W-1:0]   osc;
    } slot_fields_t;

    // flat index addresses the phase memory,
    // the fields select the offset and tag the sample
    typedef union packed {
        logic [`SLOT_W-1:0] flat;
        slot_fields_t       f;
    } slot_tag_u;

endpackage

// File: include/osc_macros.svh
`ifndef OSC_MACROS_SVH
`define OSC_MACROS_SVH

// bank size
`define VOICES        8
`define OSCS          4
`define VOICE_W       3
`define OSC_W         2
`define SLOT_W        5

// datapath widths
`define ACC_W         24
`define PHASE_W       11
`define SAMPLE_W      17
`define OFFSET_W      8

// register bus
`define REG_ADDR_W    7
`define REG_DATA_W    8
`define OFFSET_BASE   6
`define OFFSET_STRIDE 16

// quarter-wave table
`define QUARTER_LEN   512
`define SINE_AMP      65535

`endif
